//--- compile.f
+incdir+source
+incdir+tb
source/modexp_pkg.sv
source/word_mul_add.sv
source/mont_mul.sv
source/operand_store.sv
source/exp_sequencer.sv
source/modexp_top.sv
tb/tb_modexp.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the modexp testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f compile.f --top-module tb_modexp -Mdir obj_dir -o sim_modexp
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_modexp > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    echo "simulation reported errors"
    exit 1
fi

echo "simulation passed"
exit 0

//--- source/exp_sequencer.sv
// square-and-multiply control and readout

`timescale 1ns/1ps
`include "modexp_macros.svh"

module exp_sequencer import modexp_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start_input,
    input  logic  start_compute,
    input  logic  get_result,
    input  logic  load_done,
    input  big_t  m_val,
    input  big_t  e_val,
    input  big_t  r_val,
    input  big_t  t_val,
    input  logic  mul_done,
    input  big_t  mul_result,
    output logic  load_start,
    output logic  mul_start,
    output big_t  a,
    output big_t  b,
    output logic  done,
    output logic  result_valid,
    output word_t result_word
);

    typedef enum logic [3:0] {
        idle, loading, loaded, to_mont, scan, square, multiply, from_mont, complete, unload
    } state_t;

    localparam logic [`WORD_IDX_WIDTH-1:0] last_word = `WORD_IDX_WIDTH'(`NUM_WORDS - 1);
    localparam logic [`EXP_BITS_LOG-1:0] top_bit = `EXP_BITS_LOG'(`BIG_WIDTH - 1);
    localparam big_t big_one = big_t'(1);

    state_t state;
    big_t m_bar;
    big_t c_bar;
    logic [`EXP_BITS_LOG-1:0] bit_idx;     // current exponent bit
    logic [`WORD_IDX_WIDTH-1:0] word_cnt;  // readout position

    assign load_start = start_input && (state == idle || state == loaded);
    assign done       = (state == complete);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= idle;
            m_bar        <= '0;
            c_bar        <= '0;
            a            <= '0;
            b            <= '0;
            bit_idx      <= '0;
            word_cnt     <= '0;
            mul_start    <= 1'b0;
            result_valid <= 1'b0;
            result_word  <= '0;
        end else begin
            mul_start <= 1'b0;
            case (state)
                idle: if (load_start) state <= loading;
                loading: if (load_done) state <= loaded;
                loaded: begin
                    if (load_start) begin
                        state <= loading;          // reload
                    end else if (start_compute) begin
                        a         <= m_val;        // m_bar = MonPro(m, t)
                        b         <= t_val;
                        mul_start <= 1'b1;
                        c_bar     <= r_val;        // Montgomery one
                        bit_idx   <= top_bit;
                        state     <= to_mont;
                    end
                end
                to_mont: if (mul_done) begin
                    m_bar <= mul_result;
                    state <= scan;
                end
                scan: begin                         // look for the leading one
                    if (e_val[bit_idx]) begin
                        a         <= c_bar;
                        b         <= c_bar;
                        mul_start <= 1'b1;
                        state     <= square;
                    end else if (bit_idx == '0) begin
                        a         <= big_one;      // zero exponent
                        b         <= c_bar;
                        mul_start <= 1'b1;
                        state     <= from_mont;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
                square: if (mul_done) begin
                    c_bar     <= mul_result;
                    mul_start <= 1'b1;
                    if (e_val[bit_idx]) begin
                        a     <= mul_result;
                        b     <= m_bar;
                        state <= multiply;
                    end else if (bit_idx == '0) begin
                        a     <= big_one;
                        b     <= mul_result;
                        state <= from_mont;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                        a       <= mul_result;
                        b       <= mul_result;
                    end
                end
                multiply: if (mul_done) begin
                    c_bar     <= mul_result;
                    mul_start <= 1'b1;
                    if (bit_idx == '0) begin
                        a     <= big_one;
                        b     <= mul_result;
                        state <= from_mont;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                        a       <= mul_result;
                        b       <= mul_result;
                        state   <= square;
                    end
                end
                from_mont: if (mul_done) begin
                    c_bar <= mul_result;
                    state <= complete;
                end
                complete: if (get_result) begin
                    result_word  <= c_bar[`WORD_WIDTH-1:0];
                    c_bar        <= c_bar >> `WORD_WIDTH;
                    result_valid <= 1'b1;
                    word_cnt     <= '0;
                    state        <= unload;
                end
                unload: begin
                    if (word_cnt == last_word) begin
                        result_valid <= 1'b0;
                        result_word  <= '0;
                        state        <= loaded;    // operands still held
                    end else begin
                        result_word <= c_bar[`WORD_WIDTH-1:0];
                        c_bar       <= c_bar >> `WORD_WIDTH;
                        word_cnt    <= word_cnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    valid_only_in_unload: assert property (
        @(posedge clk) disable iff (reset) result_valid |-> state == unload
    );

endmodule

//--- source/modexp_macros.svh
// modexp size definitions

`ifndef MODEXP_MACROS_SVH
`define MODEXP_MACROS_SVH

// bits per word
`define WORD_WIDTH 32

// words per operand
`define NUM_WORDS 4

// full operand width
`define BIG_WIDTH (`WORD_WIDTH * `NUM_WORDS)

// word index width, log2 of NUM_WORDS
`define WORD_IDX_WIDTH 2

// exponent bit index, covers BIG_WIDTH bits
`define EXP_BITS_LOG 7

`endif

//--- source/modexp_pkg.sv
// modexp shared types

`include "modexp_macros.svh"

package modexp_pkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [`BIG_WIDTH-1:0] big_t;

    // one word of every operand per load cycle
    typedef struct packed {
        word_t m;
        word_t e;
        word_t n;
        word_t r;
        word_t t;
    } operand_words_t;

    // x*y + z + carry_in
    typedef struct packed {
        word_t x;
        word_t y;
        word_t z;
        word_t carry_in;
    } mac_req_t;

    typedef struct packed {
        word_t sum;    // low word
        word_t carry;  // high word
    } mac_rsp_t;

endpackage

//--- source/modexp_top.sv
// modular exponentiation engine

`timescale 1ns/1ps
`include "modexp_macros.svh"

module modexp_top import modexp_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           start_input,
    input  logic           start_compute,
    input  logic           get_result,
    input  operand_words_t operand_in,
    input  word_t          nprime0,
    output logic           done,
    output logic           result_valid,
    output word_t          result_word
);

    logic load_start;
    logic load_done;
    logic mul_start;
    logic mul_done;
    big_t m_val;
    big_t e_val;
    big_t n_val;
    big_t r_val;
    big_t t_val;
    big_t a;
    big_t b;
    big_t mul_result;

    operand_store u_operand_store (
        .clk        (clk),
        .reset      (reset),
        .load_start (load_start),
        .operand_in (operand_in),
        .load_done  (load_done),
        .m_val      (m_val),
        .e_val      (e_val),
        .n_val      (n_val),
        .r_val      (r_val),
        .t_val      (t_val)
    );

    exp_sequencer u_exp_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start_input   (start_input),
        .start_compute (start_compute),
        .get_result    (get_result),
        .load_done     (load_done),
        .m_val         (m_val),
        .e_val         (e_val),
        .r_val         (r_val),
        .t_val         (t_val),
        .mul_done      (mul_done),
        .mul_result    (mul_result),
        .load_start    (load_start),
        .mul_start     (mul_start),
        .a             (a),
        .b             (b),
        .done          (done),
        .result_valid  (result_valid),
        .result_word   (result_word)
    );

    mont_mul u_mont_mul (
        .clk        (clk),
        .reset      (reset),
        .mul_start  (mul_start),
        .a          (a),
        .b          (b),
        .n_val      (n_val),
        .nprime0    (nprime0),
        .mul_done   (mul_done),
        .mul_result (mul_result)
    );

endmodule

//--- source/mont_mul.sv
// Montgomery product, word-serial CIOS

`timescale 1ns/1ps
`include "modexp_macros.svh"

module mont_mul import modexp_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  mul_start,
    input  big_t  a,
    input  big_t  b,
    input  big_t  n_val,
    input  word_t nprime0,
    output logic  mul_done,
    output big_t  mul_result
);

    typedef enum logic [2:0] {
        idle, acc, fold, quot, reduce, top_lo, top_hi, finish
    } state_t;

    localparam logic [`WORD_IDX_WIDTH-1:0] last_word = `WORD_IDX_WIDTH'(`NUM_WORDS - 1);

    state_t state;
    logic collect;                      // high on the cycle mac_rsp is read
    logic [`WORD_IDX_WIDTH-1:0] i;      // outer word of a
    logic [`WORD_IDX_WIDTH-1:0] j;      // inner word
    word_t v [`NUM_WORDS + 2];
    word_t carry;
    word_t q_word;                      // quotient word for this outer step
    mac_req_t mac_req;
    mac_rsp_t mac_rsp;
    logic [`BIG_WIDTH+`WORD_WIDTH-1:0] v_low;
    logic [`BIG_WIDTH+`WORD_WIDTH-1:0] n_ext;
    logic [`BIG_WIDTH+`WORD_WIDTH-1:0] v_diff;

    word_mul_add u_word_mul_add (
        .clk     (clk),
        .reset   (reset),
        .mac_req (mac_req),
        .mac_rsp (mac_rsp)
    );

    // request is held through both cycles of a word op
    always_comb begin
        mac_req = '0;
        case (state)
            acc: begin
                mac_req.x        = a[i*`WORD_WIDTH +: `WORD_WIDTH];
                mac_req.y        = b[j*`WORD_WIDTH +: `WORD_WIDTH];
                mac_req.z        = v[j];
                mac_req.carry_in = carry;
            end
            fold: begin
                mac_req.z        = v[`NUM_WORDS];
                mac_req.carry_in = carry;
            end
            quot: begin
                mac_req.x = v[0];
                mac_req.y = nprime0;        // only the low word is kept
            end
            reduce: begin
                mac_req.x        = q_word;
                mac_req.y        = n_val[j*`WORD_WIDTH +: `WORD_WIDTH];
                mac_req.z        = v[j];
                mac_req.carry_in = carry;
            end
            top_lo: begin
                mac_req.z        = v[`NUM_WORDS];
                mac_req.carry_in = carry;
            end
            top_hi: begin
                mac_req.z        = v[`NUM_WORDS + 1];
                mac_req.carry_in = carry;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= idle;
            collect  <= 1'b0;
            i        <= '0;
            j        <= '0;
            carry    <= '0;
            q_word   <= '0;
            mul_done <= 1'b0;
            for (int k = 0; k < `NUM_WORDS + 2; k++) begin
                v[k] <= '0;
            end
        end else begin
            mul_done <= 1'b0;
            if (state != idle && state != finish) begin
                collect <= ~collect;
            end
            case (state)
                idle: if (mul_start) state <= acc;
                acc: if (collect) begin
                    v[j]  <= mac_rsp.sum;
                    carry <= mac_rsp.carry;
                    j     <= j + 1'b1;
                    if (j == last_word) state <= fold;
                end
                fold: if (collect) begin
                    v[`NUM_WORDS]     <= mac_rsp.sum;
                    v[`NUM_WORDS + 1] <= mac_rsp.carry;
                    carry             <= '0;
                    state             <= quot;
                end
                quot: if (collect) begin
                    q_word <= mac_rsp.sum;
                    state  <= reduce;
                end
                reduce: if (collect) begin
                    if (j != '0) v[j - 1'b1] <= mac_rsp.sum;   // shift down one word
                    carry <= mac_rsp.carry;
                    j     <= j + 1'b1;
                    if (j == last_word) state <= top_lo;
                end
                top_lo: if (collect) begin
                    v[`NUM_WORDS - 1] <= mac_rsp.sum;
                    carry             <= mac_rsp.carry;
                    state             <= top_hi;
                end
                top_hi: if (collect) begin
                    v[`NUM_WORDS] <= mac_rsp.sum;
                    carry         <= '0;                  // fresh carry per outer word
                    i             <= i + 1'b1;
                    state         <= (i == last_word) ? finish : acc;
                end
                finish: begin
                    mul_done <= 1'b1;
                    q_word   <= '0;
                    state    <= idle;
                    for (int k = 0; k < `NUM_WORDS + 2; k++) begin
                        v[k] <= '0;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_comb begin
        for (int k = 0; k <= `NUM_WORDS; k++) begin
            v_low[k*`WORD_WIDTH +: `WORD_WIDTH] = v[k];
        end
    end

    assign n_ext  = {{`WORD_WIDTH{1'b0}}, n_val};
    assign v_diff = v_low - n_ext;

    // CIOS leaves v below 2n, one subtraction brings it under n
    always_ff @(posedge clk) begin
        if (state == finish) begin
            mul_result <= (v_low >= n_ext) ? v_diff[`BIG_WIDTH-1:0] : v_low[`BIG_WIDTH-1:0];
        end
    end

    mul_start_when_idle: assert property (
        @(posedge clk) disable iff (reset) mul_start |-> state == idle
    );

endmodule

//--- source/operand_store.sv
// operand capture registers

`timescale 1ns/1ps
`include "modexp_macros.svh"

module operand_store import modexp_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           load_start,
    input  operand_words_t operand_in,
    output logic           load_done,
    output big_t           m_val,
    output big_t           e_val,
    output big_t           n_val,
    output big_t           r_val,
    output big_t           t_val
);

    localparam logic [`WORD_IDX_WIDTH-1:0] last_word = `WORD_IDX_WIDTH'(`NUM_WORDS - 1);

    logic active;                          // words are arriving
    logic [`WORD_IDX_WIDTH-1:0] word_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            word_idx <= '0;
        end else if (load_start) begin
            active   <= 1'b1;
            word_idx <= '0;
        end else if (active) begin
            word_idx <= word_idx + 1'b1;
            if (word_idx == last_word) active <= 1'b0;
        end
    end

    assign load_done = active && (word_idx == last_word);

    // word 0 first, into the low end
    always_ff @(posedge clk) begin
        if (active) begin
            m_val[word_idx*`WORD_WIDTH +: `WORD_WIDTH] <= operand_in.m;
            e_val[word_idx*`WORD_WIDTH +: `WORD_WIDTH] <= operand_in.e;
            n_val[word_idx*`WORD_WIDTH +: `WORD_WIDTH] <= operand_in.n;
            r_val[word_idx*`WORD_WIDTH +: `WORD_WIDTH] <= operand_in.r;
            t_val[word_idx*`WORD_WIDTH +: `WORD_WIDTH] <= operand_in.t;
        end
    end

endmodule

//--- source/word_mul_add.sv
// word multiply-accumulate, one cycle

`timescale 1ns/1ps
`include "modexp_macros.svh"

module word_mul_add import modexp_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mac_req_t mac_req,
    output mac_rsp_t mac_rsp
);

    typedef logic [2*`WORD_WIDTH-1:0] dword_t;

    dword_t full;

    // cannot overflow: (2^w-1)^2 + 2*(2^w-1) = 2^2w - 1
    assign full = dword_t'(mac_req.x) * dword_t'(mac_req.y)
                + dword_t'(mac_req.z) + dword_t'(mac_req.carry_in);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mac_rsp <= '0;
        end else begin
            mac_rsp.sum   <= full[`WORD_WIDTH-1:0];
            mac_rsp.carry <= full[2*`WORD_WIDTH-1:`WORD_WIDTH];
        end
    end

endmodule

//--- tb/tb_modexp_tasks.svh
// modexp reference model and directed tests

`ifndef TB_MODEXP_TASKS_SVH
`define TB_MODEXP_TASKS_SVH

typedef logic [2*`BIG_WIDTH-1:0] wide_t;   // holds any product of two operands

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic random_big(output big_t val);
    val = '0;
    for (int k = 0; k < `BIG_WIDTH; k++) begin
        lfsr_state = lfsr_next(lfsr_state);
        val[k]     = lfsr_state[0];
    end
endtask

task automatic random_modulus(output big_t n);
    random_big(n);
    n[0]            = 1'b1;   // Montgomery needs an odd modulus
    n[`BIG_WIDTH-1] = 1'b1;
endtask

function automatic big_t mod_mul(input big_t x, input big_t y, input big_t n);
    wide_t prod;
    prod = wide_t'(x) * wide_t'(y);
    return big_t'(prod % wide_t'(n));
endfunction

function automatic big_t mod_pow(input big_t m, input big_t e, input big_t n);
    big_t c;
    big_t base;
    c    = big_t'(1);
    base = m % n;
    for (int k = `BIG_WIDTH - 1; k >= 0; k--) begin
        c = mod_mul(c, c, n);
        if (e[k]) c = mod_mul(c, base, n);
    end
    return c;
endfunction

// Newton steps from n0, which is already exact in the low 3 bits
function automatic word_t neg_inverse(input word_t n0);
    word_t x;
    x = n0;
    for (int k = 0; k < 4; k++) begin
        x = x * (word_t'(2) - n0 * x);
    end
    return -x;
endfunction

task automatic load_operands(input big_t m, input big_t e, input big_t n);
    big_t r;
    big_t t;
    r = big_t'((wide_t'(1) << `BIG_WIDTH) % wide_t'(n));
    t = mod_mul(r, r, n);                  // R^2 mod n
    nprime0     = neg_inverse(n[`WORD_WIDTH-1:0]);
    start_input = 1'b1;
    @(negedge clk);
    start_input = 1'b0;
    for (int k = 0; k < `NUM_WORDS; k++) begin
        operand_in.m = m[k*`WORD_WIDTH +: `WORD_WIDTH];
        operand_in.e = e[k*`WORD_WIDTH +: `WORD_WIDTH];
        operand_in.n = n[k*`WORD_WIDTH +: `WORD_WIDTH];
        operand_in.r = r[k*`WORD_WIDTH +: `WORD_WIDTH];
        operand_in.t = t[k*`WORD_WIDTH +: `WORD_WIDTH];
        @(negedge clk);
    end
    operand_in = '0;
endtask

task automatic strobe_compute();
    start_compute = 1'b1;
    @(negedge clk);
    start_compute = 1'b0;
endtask

task automatic wait_done(input string name, output logic ok);
    int cycles;
    cycles = 0;
    while (!done && cycles < done_timeout) begin
        @(negedge clk);
        cycles++;
    end
    ok = done;
    if (!ok) begin
        error_count++;
        $display("timeout in %s: done did not rise within %0d cycles", name, done_timeout);
    end
endtask

// words come one per cycle from the cycle after the strobe
task automatic read_result(input string name, output big_t value);
    int count;
    value      = '0;
    count      = 0;
    get_result = 1'b1;
    @(negedge clk);
    get_result = 1'b0;
    while (result_valid && count < valid_timeout) begin
        if (count < `NUM_WORDS) value[count*`WORD_WIDTH +: `WORD_WIDTH] = result_word;
        count++;
        @(negedge clk);
    end
    check_count++;
    if (count != `NUM_WORDS) begin
        error_count++;
        $display("Fail %s valid cycles: expected %0d, actual %0d", name, `NUM_WORDS, count);
    end
    check_count++;
    if (done) begin
        error_count++;
        $display("done stayed high after the readout in %s", name);
    end
endtask

task automatic check_result(input string name, input big_t expected, input big_t actual);
    for (int k = 0; k < `NUM_WORDS; k++) begin
        check_count++;
        if (actual[k*`WORD_WIDTH +: `WORD_WIDTH] !== expected[k*`WORD_WIDTH +: `WORD_WIDTH]) begin
            error_count++;
            $display("Fail %s word %0d: expected %h, actual %h", name, k,
                     expected[k*`WORD_WIDTH +: `WORD_WIDTH],
                     actual[k*`WORD_WIDTH +: `WORD_WIDTH]);
        end
    end
endtask

task automatic run_case(input string name, input big_t m, input big_t e, input big_t n,
                        input big_t expected);
    big_t actual;
    logic ok;
    load_operands(m, e, n);
    strobe_compute();
    wait_done(name, ok);
    if (ok) begin
        read_result(name, actual);
        check_result(name, expected, actual);
    end
endtask

task automatic known_case();
    run_case("known_case", big_t'(4), big_t'(13), big_t'(497), big_t'(445));
endtask

task automatic random_moduli();
    big_t n;
    big_t m;
    big_t e;
    for (int k = 0; k < 3; k++) begin
        random_modulus(n);
        random_big(m);
        random_big(e);
        m = m % n;
        run_case($sformatf("random_%0d", k), m, e, n, mod_pow(m, e, n));
    end
endtask

task automatic small_exponents();
    big_t n;
    big_t m;
    random_modulus(n);
    random_big(m);
    m = m % n;
    run_case("exp_one", m, big_t'(1), n, m);
    run_case("exp_zero", m, big_t'(0), n, big_t'(1));
    run_case("exp_one_wrap", big_t'(1000), big_t'(1), big_t'(497), big_t'(6));  // m above n
endtask

task automatic readout_order();
    big_t n;
    big_t m;
    big_t actual;
    logic ok;
    int   stray;
    random_modulus(n);
    random_big(m);
    m = m % n;
    load_operands(m, big_t'(16'hbeef), n);
    strobe_compute();
    wait_done("readout", ok);
    if (ok) begin
        repeat (3) @(negedge clk);
        check_count++;
        if (!done) begin
            error_count++;
            $display("done fell before get_result in readout");
        end
        read_result("readout", actual);
        check_result("readout", mod_pow(m, big_t'(16'hbeef), n), actual);
        stray      = 0;
        get_result = 1'b1;           // ignored since done is low
        @(negedge clk);
        get_result = 1'b0;
        repeat (`NUM_WORDS + 2) begin
            if (result_valid) stray++;
            @(negedge clk);
        end
        check_count++;
        if (stray != 0) begin
            error_count++;
            $display("Fail readout late strobe: expected 0, actual %0d", stray);
        end
    end
endtask

task automatic reload_run();
    big_t n;
    big_t m;
    big_t e;
    big_t actual;
    logic ok;
    int   busy_out;
    random_modulus(n);
    random_big(m);
    random_big(e);
    m = m % n;
    load_operands(m, e, n);
    strobe_compute();
    repeat (300) @(negedge clk);
    get_result    = 1'b1;            // engine is inside the exponent loop
    start_compute = 1'b1;
    @(negedge clk);
    get_result    = 1'b0;
    start_compute = 1'b0;
    busy_out = 0;
    repeat (4) begin
        if (result_valid || done) busy_out++;
        @(negedge clk);
    end
    check_count++;
    if (busy_out != 0) begin
        error_count++;
        $display("Fail reload busy strobes: expected 0, actual %0d", busy_out);
    end
    wait_done("reload", ok);
    if (ok) begin
        read_result("reload", actual);
        check_result("reload", mod_pow(m, e, n), actual);
    end
endtask

`endif

//--- tb/tb_modexp.sv
// modexp testbench

`timescale 1ns/1ps
`include "modexp_macros.svh"

module tb_modexp import modexp_pkg::*; ();

    localparam logic [31:0] lfsr_seed = 32'h92cf_3b98;
    localparam int done_timeout  = 40000;  // a full exponent needs about 258 products
    localparam int valid_timeout = 16;

    logic           clk;
    logic           reset;
    logic           start_input;
    logic           start_compute;
    logic           get_result;
    operand_words_t operand_in;
    word_t          nprime0;
    logic           done;
    logic           result_valid;
    word_t          result_word;

    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;

    modexp_top u_modexp_top (
        .clk           (clk),
        .reset         (reset),
        .start_input   (start_input),
        .start_compute (start_compute),
        .get_result    (get_result),
        .operand_in    (operand_in),
        .nprime0       (nprime0),
        .done          (done),
        .result_valid  (result_valid),
        .result_word   (result_word)
    );

    `include "tb_modexp_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset         = 1'b1;
        start_input   = 1'b0;
        start_compute = 1'b0;
        get_result    = 1'b0;
        operand_in    = '0;
        nprime0       = '0;
        lfsr_state    = lfsr_seed;
        error_count   = 0;
        check_count   = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_count++;
        if (done || result_valid || result_word != '0) begin
            error_count++;
            $display("outputs were not cleared by reset");
        end
        reset = 1'b0;

        known_case();
        random_moduli();
        small_exponents();
        readout_order();
        reload_run();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
